// File: verilog/rv_fetch_cfg.svh
`ifndef RV_FETCH_CFG_SVH
`define RV_FETCH_CFG_SVH

// instruction memory depth in 32-bit words
`define IMEM_WORDS 256

// addi x0, x0, 0
`define NOP_IR 32'h0000_0013

// pc shown while a bubble sits in the output registers
`define NOP_PC 32'hffff_ffff

`endif

// File: verilog/rv_fetch_pkg.sv
`include "rv_fetch_cfg.svh"

package rv_fetch_pkg;

    typedef logic [31:0] word_t;    // instruction, address or pc
    typedef logic [15:0] half_t;    // one rvc parcel

    // word index into the instruction memory
    typedef logic [$clog2(`IMEM_WORDS)-1:0] imem_idx_t;

    typedef enum logic [4:0] {
        FS_STARTUP        = 5'b00001,
        FS_ALIGNED        = 5'b00010,
        FS_UNALIGNED      = 5'b00100,   // upper half of last word still pending
        FS_UNALIGNED_JUMP = 5'b01000,   // first word of a halfword target
        FS_HALTED         = 5'b10000
    } fetch_state_t;

endpackage

// File: verilog/rv_imem.sv
`timescale 1ns/1ps

`include "rv_fetch_cfg.svh"

module rv_imem
    import rv_fetch_pkg::*;
(
    input  logic      clk_i,
    input  logic      we_i,
    input  imem_idx_t waddr_i,
    input  word_t     wdata_i,
    input  word_t     raddr_i,     // byte address
    output word_t     rdata_o
);

    word_t     mem [`IMEM_WORDS];
    word_t     rdata_r;
    imem_idx_t ridx;

    assign ridx    = imem_idx_t'(raddr_i[31:2]); // drop byte offset
    assign rdata_o = rdata_r;

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;   // program load
        end
        rdata_r <= mem[ridx];
    end

    // fetch only ever asks for whole words
    a_raddr_aligned : assert property (
        @(posedge clk_i) raddr_i[1:0] == 2'b00
    ) else $error("imem read address %h not word aligned", raddr_i);

endmodule

// File: verilog/rv_decompress.sv
`timescale 1ns/1ps

module rv_decompress
    import rv_fetch_pkg::*;
(
    input  word_t ir_i,
    output word_t ir_o,
    output logic  compressed_o
);

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    half_t       c_ir;
    logic [4:0]  rd;         // full rd / rs1 field, bits 11:7
    logic [4:0]  rs2;        // full rs2 field, bits 6:2
    logic [4:0]  rd_p;       // x8..x15 from bits 4:2
    logic [4:0]  rs1_p;      // x8..x15 from bits 9:7
    logic [11:0] imm6_sx;
    logic [11:0] lsw_off;
    logic [11:0] j_off;
    logic [20:0] jal_imm;
    logic [19:0] lui_imm;
    word_t       exp_ir;

    assign c_ir         = ir_i[15:0];
    assign compressed_o = (ir_i[1:0] != 2'b11);

    assign rd    = c_ir[11:7];
    assign rs2   = c_ir[6:2];
    assign rd_p  = {2'b01, c_ir[4:2]};
    assign rs1_p = {2'b01, c_ir[9:7]};

    // c.addi / c.li immediate
    assign imm6_sx = {{6{c_ir[12]}}, c_ir[12], c_ir[6:2]};

    // c.lw / c.sw offset, word scaled
    assign lsw_off = {5'b0, c_ir[5], c_ir[12:10], c_ir[6], 2'b00};

    // c.j offset, bits scattered across the parcel
    assign j_off = {c_ir[12], c_ir[8], c_ir[10:9], c_ir[6], c_ir[7],
                    c_ir[2], c_ir[11], c_ir[5:3], 1'b0};
    assign jal_imm = {{9{j_off[11]}}, j_off};

    assign lui_imm = {{14{c_ir[12]}}, c_ir[12], c_ir[6:2]};

    always_comb begin
        exp_ir = '0;   // illegal unless matched below
        case ({c_ir[15:13], c_ir[1:0]})
            5'b010_00: begin    // c.lw
                exp_ir = {lsw_off, rs1_p, 3'b010, rd_p, OPC_LOAD};
            end
            5'b110_00: begin    // c.sw
                exp_ir = {lsw_off[11:5], rd_p, rs1_p, 3'b010, lsw_off[4:0], OPC_STORE};
            end
            5'b000_01: begin    // c.addi
                exp_ir = {imm6_sx, rd, 3'b000, rd, OPC_OP_IMM};
            end
            5'b010_01: begin    // c.li
                exp_ir = {imm6_sx, 5'd0, 3'b000, rd, OPC_OP_IMM};
            end
            5'b011_01: begin
                // rd == x2 is c.addi16sp, not handled here
                if (rd != 5'd2 && {c_ir[12], c_ir[6:2]} != 6'd0) begin
                    exp_ir = {lui_imm, rd, OPC_LUI};
                end
            end
            5'b101_01: begin    // c.j
                exp_ir = {jal_imm[20], jal_imm[10:1], jal_imm[11], jal_imm[19:12],
                          5'd0, OPC_JAL};
            end
            5'b100_10: begin
                if (rs2 != 5'd0) begin
                    if (c_ir[12]) begin
                        exp_ir = {7'd0, rs2, rd, 3'b000, rd, OPC_OP};     // c.add
                    end else begin
                        exp_ir = {7'd0, rs2, 5'd0, 3'b000, rd, OPC_OP};   // c.mv
                    end
                end
                // rs2 == 0 is jr / jalr / ebreak, left illegal
            end
            default: begin
                exp_ir = '0;
            end
        endcase
    end

    assign ir_o = compressed_o ? exp_ir : ir_i;   // full-size words pass through

endmodule

// File: verilog/rv_fetch.sv
`timescale 1ns/1ps

`include "rv_fetch_cfg.svh"

module rv_fetch
    import rv_fetch_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  halt_i,
    input  logic  ready_i,
    input  word_t jmp_addr_i,
    input  logic  jmp_valid_i,
    output word_t imem_addr_o,
    input  word_t imem_data_i,
    output word_t raw_ir_o,
    input  word_t exp_ir_i,
    input  logic  compressed_i,
    output word_t pc_o,
    output word_t ir_o,
    output word_t pc_next_o
);

    fetch_state_t state_r;
    fetch_state_t state_next;
    logic [1:0]   startup_r;     // shifts out the memory latency

    word_t imem_addr;
    word_t imem_addr_r;
    word_t pc_r;
    word_t ir_r;
    word_t pc_next_r;
    word_t jmp_addr_r;
    half_t saved_half_r;         // upper parcel of the previous word

    logic go;
    logic jmp_ok;
    logic waiting;
    logic start_aligned;
    logic start_unaligned;
    logic halt;
    logic aligned_jump;
    logic unaligned_jump_1;
    logic unaligned_jump_2;
    logic stay_aligned;
    logic lose_alignment;
    logic stay_unaligned;
    logic gain_alignment;
    logic consume;               // an instruction lands in ir_r
    logic bubble;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            startup_r <= 2'b11;
        end else begin
            startup_r <= {1'b0, startup_r[1]};
        end
    end

    always_comb begin
        go               = !halt_i && ready_i;
        jmp_ok           = go && jmp_valid_i && state_r inside
                           {FS_ALIGNED, FS_UNALIGNED, FS_UNALIGNED_JUMP};
        waiting          = (state_r == FS_STARTUP) && startup_r[0];
        start_aligned    = (state_r == FS_STARTUP) && !startup_r[0] && go && !compressed_i;
        start_unaligned  = (state_r == FS_STARTUP) && !startup_r[0] && go && compressed_i;
        halt             = (state_r == FS_HALTED) || halt_i;
        aligned_jump     = jmp_ok && !jmp_addr_i[1];
        unaligned_jump_1 = jmp_ok && jmp_addr_i[1];
        unaligned_jump_2 = (state_r == FS_UNALIGNED_JUMP) && go && !jmp_valid_i;
        stay_aligned     = (state_r == FS_ALIGNED) && go && !jmp_valid_i && !compressed_i;
        lose_alignment   = (state_r == FS_ALIGNED) && go && !jmp_valid_i && compressed_i;
        stay_unaligned   = (state_r == FS_UNALIGNED) && go && !jmp_valid_i && !compressed_i;
        gain_alignment   = (state_r == FS_UNALIGNED) && go && !jmp_valid_i && compressed_i;

        consume = start_aligned || start_unaligned || stay_aligned || lose_alignment
                  || stay_unaligned || gain_alignment;
        bubble  = waiting || halt || aligned_jump || unaligned_jump_1 || unaligned_jump_2;
    end

    always_comb begin
        if (halt) begin
            state_next = FS_HALTED;       // sticky until reset
        end else if (waiting) begin
            state_next = FS_STARTUP;
        end else if (start_aligned || stay_aligned || gain_alignment || aligned_jump) begin
            state_next = FS_ALIGNED;
        end else if (start_unaligned || stay_unaligned || lose_alignment
                     || unaligned_jump_2) begin
            state_next = FS_UNALIGNED;
        end else if (unaligned_jump_1) begin
            state_next = FS_UNALIGNED_JUMP;
        end else begin
            state_next = state_r;         // back-pressure
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_r <= FS_STARTUP;
        end else begin
            state_r <= state_next;
        end
    end

    // word handed to the expander
    always_comb begin
        case (state_r)
            FS_STARTUP, FS_ALIGNED: raw_ir_o = imem_data_i;
            FS_UNALIGNED:           raw_ir_o = {imem_data_i[15:0], saved_half_r};
            default:                raw_ir_o = `NOP_IR;
        endcase
    end

    always_comb begin
        if (halt || waiting) begin
            imem_addr = '0;
        end else if (aligned_jump || unaligned_jump_1) begin
            imem_addr = {jmp_addr_i[31:2], 2'b00};
        end else if (consume && !gain_alignment || unaligned_jump_2) begin
            imem_addr = imem_addr_r + 32'd4;
        end else begin
            imem_addr = imem_addr_r;      // stall or re-read after gaining alignment
        end
    end

    assign imem_addr_o = imem_addr;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            imem_addr_r <= '0;
            ir_r        <= `NOP_IR;
            pc_r        <= `NOP_PC;
            pc_next_r   <= `NOP_PC;
        end else begin
            imem_addr_r <= imem_addr;
            if (bubble) begin
                ir_r <= `NOP_IR;
                pc_r <= `NOP_PC;
            end else if (consume) begin
                ir_r <= exp_ir_i;
                pc_r <= pc_next_r;
            end
            if (halt) begin
                pc_next_r <= `NOP_PC;
            end else if (waiting) begin
                pc_next_r <= '0;
            end else if (consume) begin
                pc_next_r <= pc_next_r + (compressed_i ? 32'd2 : 32'd4);
            end else if (aligned_jump || unaligned_jump_1) begin
                pc_next_r <= jmp_addr_i;
            end else if (unaligned_jump_2) begin
                pc_next_r <= jmp_addr_r;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (unaligned_jump_1) begin
            jmp_addr_r <= jmp_addr_i;
        end
        if (start_unaligned || lose_alignment || stay_unaligned || unaligned_jump_2) begin
            saved_half_r <= imem_data_i[31:16];
        end
    end

    assign pc_o      = pc_r;
    assign ir_o      = ir_r;
    assign pc_next_o = pc_next_r;

    a_state_onehot : assert property (
        @(posedge clk_i) disable iff (!rst_n_i) $onehot(state_r)
    );

    // decode must never hand over an odd target
    a_jmp_halfword : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (aligned_jump || unaligned_jump_1) |-> !jmp_addr_i[0]
    );

    a_halt_addr_zero : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (state_r == FS_HALTED) |-> (imem_addr_o == '0)
    );

endmodule

// File: verilog/rv_fetch_top.sv
`timescale 1ns/1ps

module rv_fetch_top
    import rv_fetch_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      halt_i,
    input  logic      ready_i,
    input  logic      jmp_valid_i,
    input  word_t     jmp_addr_i,
    input  logic      load_we_i,     // only while in reset
    input  imem_idx_t load_addr_i,
    input  word_t     load_data_i,
    output word_t     pc_o,
    output word_t     ir_o,
    output word_t     pc_next_o
);

    word_t imem_addr;
    word_t imem_data;
    word_t raw_ir;
    word_t exp_ir;
    logic  compressed;

    rv_imem u_imem (
        .clk_i   (clk_i),
        .we_i    (load_we_i),
        .waddr_i (load_addr_i),
        .wdata_i (load_data_i),
        .raddr_i (imem_addr),
        .rdata_o (imem_data)
    );

    rv_fetch u_fetch (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .halt_i       (halt_i),
        .ready_i      (ready_i),
        .jmp_addr_i   (jmp_addr_i),
        .jmp_valid_i  (jmp_valid_i),
        .imem_addr_o  (imem_addr),
        .imem_data_i  (imem_data),
        .raw_ir_o     (raw_ir),
        .exp_ir_i     (exp_ir),
        .compressed_i (compressed),
        .pc_o         (pc_o),
        .ir_o         (ir_o),
        .pc_next_o    (pc_next_o)
    );

    rv_decompress u_decompress (
        .ir_i         (raw_ir),
        .ir_o         (exp_ir),
        .compressed_o (compressed)
    );

endmodule

// File: testbench/tb_rv_fetch_top.sv
`timescale 1ns/1ps

`include "rv_fetch_cfg.svh"

module tb_rv_fetch_top
    import rv_fetch_pkg::*;
();

    localparam int NUM_TESTS = 7;
    localparam int MAX_EXP   = 12;
    localparam int TIMEOUT   = 200;

    logic      clk_i;
    logic      rst_n_i;
    logic      halt_i;
    logic      ready_i;
    logic      jmp_valid_i;
    word_t     jmp_addr_i;
    logic      load_we_i;
    imem_idx_t load_addr_i;
    word_t     load_data_i;
    word_t     pc_o;
    word_t     ir_o;
    word_t     pc_next_o;

    // stimulus table
    string name_tbl  [NUM_TESTS];
    word_t prog_tbl  [NUM_TESTS][16];
    int    prog_len  [NUM_TESTS];
    int    jmp_cyc   [NUM_TESTS];     // 0 means no jump
    word_t jmp_tgt   [NUM_TESTS];
    bit    rand_rdy  [NUM_TESTS];
    int    halt_cyc  [NUM_TESTS];     // 0 means no halt

    // expected consumed pairs
    word_t exp_pc    [NUM_TESTS][MAX_EXP];
    word_t exp_ir    [NUM_TESTS][MAX_EXP];
    word_t exp_next  [NUM_TESTS][MAX_EXP];
    int    exp_len   [NUM_TESTS];

    word_t got_pc[$];
    word_t got_ir[$];
    word_t got_next[$];

    int errors;
    int test_errors;
    int passed;

    rv_fetch_top u_dut (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .halt_i      (halt_i),
        .ready_i     (ready_i),
        .jmp_valid_i (jmp_valid_i),
        .jmp_addr_i  (jmp_addr_i),
        .load_we_i   (load_we_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .pc_o        (pc_o),
        .ir_o        (ir_o),
        .pc_next_o   (pc_next_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // decode side, pair taken on the next rising edge
    always @(negedge clk_i) begin
        if (rst_n_i && ready_i && ir_o != `NOP_IR) begin
            got_pc.push_back(pc_o);
            got_ir.push_back(ir_o);
            got_next.push_back(pc_next_o);
        end
    end

    task automatic set_test(input int t, input string nm, input int jc, input word_t jt,
                            input bit rr, input int hc);
        name_tbl[t] = nm;
        jmp_cyc[t]  = jc;
        jmp_tgt[t]  = jt;
        rand_rdy[t] = rr;
        halt_cyc[t] = hc;
        prog_len[t] = 0;
        exp_len[t]  = 0;
    endtask

    task automatic add_prog(input int t, input word_t w);
        prog_tbl[t][prog_len[t]] = w;
        prog_len[t]++;
    endtask

    task automatic add_exp(input int t, input word_t pc, input word_t ir, input int size);
        exp_pc[t][exp_len[t]]   = pc;
        exp_ir[t][exp_len[t]]   = ir;
        exp_next[t][exp_len[t]] = pc + size;
        exp_len[t]++;
    endtask

    // addi x31, x0, idx so every unused word differs
    function automatic word_t fill_word(input int idx);
        return (word_t'(idx) << 20) | 32'h0000_0f93;
    endfunction

    task automatic check_word(input string nm, input string what, input word_t exp_v,
                              input word_t act_v);
        if (exp_v !== act_v) begin
            $display("Fail %s %s: expected %h actual %h", nm, what, exp_v, act_v);
            test_errors++;
        end
    endtask

    task automatic check_pc(input string nm, input string what, input word_t exp_v,
                            input word_t act_v);
        if (exp_v !== act_v) begin
            $display("Fail %s %s: expected %h actual %h", nm, what, exp_v, act_v);
            test_errors++;
        end
    endtask

    task automatic build_tables();
        int t;
        set_test(0, "straight", 0, '0, 1'b0, 0);
        add_prog(0, 32'h0010_0093);
        add_prog(0, 32'h0020_0113);
        add_prog(0, 32'h0020_81b3);
        add_prog(0, 32'h0000_2203);
        add_exp(0, 0, 32'h0010_0093, 4);
        add_exp(0, 4, 32'h0020_0113, 4);
        add_exp(0, 8, 32'h0020_81b3, 4);
        add_exp(0, 12, 32'h0000_2203, 4);
        // c.li/c.addi, c.mv + straddling add, c.add, c.lw/c.sw, c.lui/c.j, addi
        for (t = 1; t <= 2; t++) begin
            set_test(t, (t == 1) ? "mixed_rvc" : "random_ready", 0, '0, t == 2, 0);
            add_prog(t, 32'h147d_4415);
            add_prog(t, 32'h0533_84a2);
            add_prog(t, 32'h9526_0094);
            add_prog(t, 32'hc40c_404c);
            add_prog(t, 32'ha021_6605);
            add_prog(t, 32'hffc6_0693);
            add_exp(t, 0, 32'h0050_0413, 2);
            add_exp(t, 2, 32'hfff4_0413, 2);
            add_exp(t, 4, 32'h0080_04b3, 2);
            add_exp(t, 6, 32'h0094_0533, 4);   // straddles words 1 and 2
            add_exp(t, 10, 32'h0095_0533, 2);
            add_exp(t, 12, 32'h0044_2583, 2);
            add_exp(t, 14, 32'h00b4_2423, 2);
            add_exp(t, 16, 32'h0000_1637, 2);
            add_exp(t, 18, 32'h0080_006f, 2);
            add_exp(t, 20, 32'hffc6_0693, 4);
        end
        set_test(3, "jump_word", 6, 32'h14, 1'b0, 0);
        set_test(4, "jump_half", 6, 32'h16, 1'b0, 0);
        for (t = 3; t <= 4; t++) begin
            add_prog(t, 32'h0010_0093);
            add_prog(t, 32'h0020_0113);
            add_prog(t, 32'h0030_0193);
            add_prog(t, 32'h0040_0213);
            add_prog(t, 32'h0050_0293);
            add_prog(t, (t == 3) ? 32'h0060_0313 : 32'h449d_4415);
            add_prog(t, 32'h0070_0393);
            add_prog(t, 32'h0080_0413);
            add_exp(t, 0, 32'h0010_0093, 4);
            add_exp(t, 4, 32'h0020_0113, 4);
            add_exp(t, 8, 32'h0030_0193, 4);
        end
        add_exp(3, 20, 32'h0060_0313, 4);
        add_exp(4, 22, 32'h0070_0493, 2);     // c.li x9, 7 in the upper half
        for (t = 3; t <= 4; t++) begin
            add_exp(t, 24, 32'h0070_0393, 4);
            add_exp(t, 28, 32'h0080_0413, 4);
        end
        set_test(5, "halt", 0, '0, 1'b0, 6);
        add_prog(5, 32'h0010_0093);
        add_prog(5, 32'h0020_0113);
        add_prog(5, 32'h0030_0193);
        add_exp(5, 0, 32'h0010_0093, 4);
        add_exp(5, 4, 32'h0020_0113, 4);
        add_exp(5, 8, 32'h0030_0193, 4);      // still on ir_o at the halt edge
        set_test(6, "illegal_rvc", 0, '0, 1'b0, 0);
        add_prog(6, 32'h4415_8082);           // c.jr x1 below c.li x8, 5
        add_prog(6, 32'h0010_0093);
        add_exp(6, 0, 32'h0000_0000, 2);
        add_exp(6, 2, 32'h0050_0413, 2);
        add_exp(6, 4, 32'h0010_0093, 4);
    endtask

    task automatic drive_cycle(input int t, input int cyc);
        ready_i     <= rand_rdy[t] ? (($urandom % 4) != 0) : 1'b1;
        jmp_valid_i <= (jmp_cyc[t] != 0) && (cyc + 1 == jmp_cyc[t]);
        jmp_addr_i  <= jmp_tgt[t];
        halt_i      <= (halt_cyc[t] != 0) && (cyc + 1 >= halt_cyc[t]);
    endtask

    task automatic run_test(input int t);
        int i;
        int cyc;
        int waited;
        bit left_nop;
        @(posedge clk_i);
        rst_n_i     <= 1'b0;
        ready_i     <= 1'b1;
        halt_i      <= 1'b0;
        jmp_valid_i <= 1'b0;
        got_pc.delete();
        got_ir.delete();
        got_next.delete();
        for (i = 0; i < 16; i++) begin
            @(posedge clk_i);
            load_we_i   <= 1'b1;
            load_addr_i <= imem_idx_t'(i);
            load_data_i <= (i < prog_len[t]) ? prog_tbl[t][i] : fill_word(i);
        end
        @(posedge clk_i);
        load_we_i <= 1'b0;
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;
        cyc     = 0;
        waited  = 0;
        while (got_ir.size() < exp_len[t] && waited < TIMEOUT) begin
            @(posedge clk_i);
            cyc++;
            waited++;
            drive_cycle(t, cyc);
        end
        if (got_ir.size() < exp_len[t]) begin
            $display("%s: instruction %0d never arrived", name_tbl[t], got_ir.size());
            test_errors++;
        end
        if (halt_cyc[t] != 0) begin
            halt_i <= 1'b1;
            waited = 0;
            @(negedge clk_i);
            while (ir_o !== `NOP_IR && waited < TIMEOUT) begin
                @(negedge clk_i);
                waited++;
            end
            if (ir_o !== `NOP_IR) begin
                $display("%s: output did not return to the no-op after halt", name_tbl[t]);
                test_errors++;
            end
            left_nop = 1'b0;
            for (i = 0; i < 20; i++) begin
                @(negedge clk_i);
                if (ir_o !== `NOP_IR) begin
                    left_nop = 1'b1;
                end
            end
            if (left_nop) begin
                $display("%s: output left the no-op while halted", name_tbl[t]);
                test_errors++;
            end
            if (got_ir.size() > exp_len[t]) begin
                $display("%s: an instruction was consumed after halt", name_tbl[t]);
                test_errors++;
            end
        end
        for (i = 0; i < exp_len[t] && i < got_ir.size(); i++) begin
            check_pc(name_tbl[t], $sformatf("pc[%0d]", i), exp_pc[t][i], got_pc[i]);
            check_word(name_tbl[t], $sformatf("ir[%0d]", i), exp_ir[t][i], got_ir[i]);
            check_pc(name_tbl[t], $sformatf("pc_next[%0d]", i), exp_next[t][i],
                     got_next[i]);
        end
    endtask

    initial begin
        int t;
        rst_n_i     = 1'b0;
        halt_i      = 1'b0;
        ready_i     = 1'b0;
        jmp_valid_i = 1'b0;
        jmp_addr_i  = '0;
        load_we_i   = 1'b0;
        load_addr_i = '0;
        load_data_i = '0;
        errors      = 0;
        passed      = 0;
        void'($urandom(32'ha3d6));
        build_tables();
        for (t = 0; t < NUM_TESTS; t++) begin
            test_errors = 0;
            run_test(t);
            if (test_errors == 0) begin
                $display("test %s: ok", name_tbl[t]);
                passed++;
            end else begin
                $display("test %s: %0d errors", name_tbl[t], test_errors);
                errors++;
            end
        end
        $display("%0d run, %0d passed, %0d failing", NUM_TESTS, passed, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+verilog
verilog/rv_fetch_pkg.sv
verilog/rv_imem.sv
verilog/rv_decompress.sv
verilog/rv_fetch.sv
verilog/rv_fetch_top.sv
testbench/tb_rv_fetch_top.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_rv_fetch_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := all tests passed

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard verilog/*.sv verilog/*.svh testbench/*.sv)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
